// File: Bender.yml
package:
  name: rsa_core

sources:
  - include_dirs:
      - .
    files:
      - rsa_pkg.sv
      - rsa_skid.sv
      - rsa_prep.sv
      - rsa_mont.sv
      - rsa_ctrl.sv
      - rsa_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rsa_core.sv

// File: compile.f
+incdir+.
rsa_pkg.sv
rsa_skid.sv
rsa_prep.sv
rsa_mont.sv
rsa_ctrl.sv
rsa_core.sv
tb_rsa_core.sv

// File: rsa_core.sv
`include "rsa_macros.svh"

module rsa_core (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_req_valid,
    output logic               o_req_ready,
    input  rsa_pkg::rsa_req_t  i_req,
    output logic               o_resp_valid,
    input  logic               i_resp_ready,
    output rsa_pkg::rsa_resp_t o_resp
);
    import rsa_pkg::*;

    logic              req_valid;
    logic              req_ready;
    rsa_req_t          req;
    logic              resp_valid;
    logic              resp_ready;
    rsa_resp_t         resp;
    logic              prep_start;
    logic [`RSA_W-1:0] prep_b;
    logic              prep_done;
    logic [`RSA_W-1:0] prep_t;
    logic              mont0_start;
    mont_op_t          mont0_op;
    logic              mont0_done;
    logic [`RSA_W-1:0] mont0_p;
    logic              mont1_start;
    mont_op_t          mont1_op;
    logic              mont1_done;
    logic [`RSA_W-1:0] mont1_p;
    logic [`RSA_W-1:0] n;

    rsa_skid #(.T(rsa_req_t)) u_req_skid (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_valid (i_req_valid),
        .o_ready (o_req_ready),
        .i_data  (i_req),
        .o_valid (req_valid),
        .i_ready (req_ready),
        .o_data  (req)
    );

    rsa_ctrl u_ctrl (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_req_valid   (req_valid),
        .o_req_ready   (req_ready),
        .i_req         (req),
        .o_resp_valid  (resp_valid),
        .i_resp_ready  (resp_ready),
        .o_resp        (resp),
        .o_prep_start  (prep_start),
        .o_prep_b      (prep_b),
        .i_prep_done   (prep_done),
        .i_prep_t      (prep_t),
        .o_mont0_start (mont0_start),
        .o_mont0_op    (mont0_op),
        .i_mont0_done  (mont0_done),
        .i_mont0_p     (mont0_p),
        .o_mont1_start (mont1_start),
        .o_mont1_op    (mont1_op),
        .i_mont1_done  (mont1_done),
        .i_mont1_p     (mont1_p),
        .o_n           (n)
    );

    rsa_prep u_prep (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (prep_start),
        .i_n     (n),
        .i_b     (prep_b),
        .o_done  (prep_done),
        .o_t     (prep_t)
    );

    // Multiply step and final conversion
    rsa_mont u_mont0 (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (mont0_start),
        .i_op    (mont0_op),
        .i_n     (n),
        .o_done  (mont0_done),
        .o_p     (mont0_p)
    );

    // Squaring step
    rsa_mont u_mont1 (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (mont1_start),
        .i_op    (mont1_op),
        .i_n     (n),
        .o_done  (mont1_done),
        .o_p     (mont1_p)
    );

    rsa_skid #(.T(rsa_resp_t)) u_resp_skid (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_valid (resp_valid),
        .o_ready (resp_ready),
        .i_data  (resp),
        .o_valid (o_resp_valid),
        .i_ready (i_resp_ready),
        .o_data  (o_resp)
    );

endmodule

// File: rsa_ctrl.sv
`include "rsa_macros.svh"

module rsa_ctrl (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_req_valid,
    output logic               o_req_ready,
    input  rsa_pkg::rsa_req_t  i_req,
    output logic               o_resp_valid,
    input  logic               i_resp_ready,
    output rsa_pkg::rsa_resp_t o_resp,
    output logic               o_prep_start,
    output logic [`RSA_W-1:0]  o_prep_b,
    input  logic               i_prep_done,
    input  logic [`RSA_W-1:0]  i_prep_t,
    output logic               o_mont0_start,
    output rsa_pkg::mont_op_t  o_mont0_op,
    input  logic               i_mont0_done,
    input  logic [`RSA_W-1:0]  i_mont0_p,
    output logic               o_mont1_start,
    output rsa_pkg::mont_op_t  o_mont1_op,
    input  logic               i_mont1_done,
    input  logic [`RSA_W-1:0]  i_mont1_p,
    output logic [`RSA_W-1:0]  o_n
);
    import rsa_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_PREP,
        S_LOOP,
        S_WAIT,
        S_FINAL,
        S_DONE
    } state_t;

    state_t                    state_q;
    logic                      req_ready_q;
    logic                      resp_valid_q;
    logic                      prep_start_q;
    logic                      mont0_start_q;
    logic                      mont1_start_q;
    logic                      seen0_q;
    logic                      seen1_q;
    logic                      fin_busy_q;
    // m only becomes a Montgomery value at the first set exponent bit
    logic                      m_set_q;
    logic [$clog2(`RSA_W)-1:0] bit_cnt_q;
    rsa_req_t                  req_q;
    rsa_resp_t                 resp_q;
    logic [`RSA_W-1:0]         m_q;
    logic [`RSA_W-1:0]         t_q;
    logic [`RSA_W-1:0]         one;
    logic                      req_fire;
    logic                      step_done;
    logic                      final_done;
    logic                      exp_bit;
    logic                      last_bit;

    assign one        = {{(`RSA_W-1){1'b0}}, 1'b1};
    assign req_fire   = (state_q == S_IDLE) && req_ready_q && i_req_valid;
    assign step_done  = (state_q == S_WAIT) && (seen0_q || i_mont0_done)
                        && (seen1_q || i_mont1_done);
    assign final_done = (state_q == S_FINAL) && fin_busy_q && i_mont0_done;
    assign exp_bit    = req_q.d[bit_cnt_q];
    assign last_bit   = (bit_cnt_q == `RSA_W - 1);

    assign o_req_ready   = req_ready_q;
    assign o_resp_valid  = resp_valid_q;
    assign o_resp        = resp_q;
    assign o_prep_start  = prep_start_q;
    assign o_prep_b      = req_q.y;
    assign o_n           = req_q.n;
    assign o_mont0_start = mont0_start_q;
    assign o_mont1_start = mont1_start_q;

    // Multiply step, or product with one to leave the Montgomery domain
    assign o_mont0_op.a = m_q;
    assign o_mont0_op.b = (state_q == S_FINAL) ? one : t_q;
    assign o_mont1_op.a = t_q;
    assign o_mont1_op.b = t_q;

    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            state_q       <= S_IDLE;
            req_ready_q   <= 1'b0;
            resp_valid_q  <= 1'b0;
            prep_start_q  <= 1'b0;
            mont0_start_q <= 1'b0;
            mont1_start_q <= 1'b0;
            seen0_q       <= 1'b0;
            seen1_q       <= 1'b0;
            fin_busy_q    <= 1'b0;
            m_set_q       <= 1'b0;
            bit_cnt_q     <= '0;
        end else begin
            prep_start_q  <= 1'b0;
            mont0_start_q <= 1'b0;
            mont1_start_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    req_ready_q <= 1'b1;
                    if (req_fire) begin
                        req_ready_q  <= 1'b0;
                        prep_start_q <= 1'b1;
                        m_set_q      <= 1'b0;
                        bit_cnt_q    <= '0;
                        state_q      <= S_PREP;
                    end
                end
                S_PREP: begin
                    if (i_prep_done) begin
                        state_q <= S_LOOP;
                    end
                end
                S_LOOP: begin
                    // Both run every bit so they stay in lockstep
                    mont0_start_q <= 1'b1;
                    mont1_start_q <= 1'b1;
                    seen0_q       <= 1'b0;
                    seen1_q       <= 1'b0;
                    state_q       <= S_WAIT;
                end
                S_WAIT: begin
                    if (i_mont0_done) begin
                        seen0_q <= 1'b1;
                    end
                    if (i_mont1_done) begin
                        seen1_q <= 1'b1;
                    end
                    if (step_done) begin
                        if (exp_bit) begin
                            m_set_q <= 1'b1;
                        end
                        bit_cnt_q  <= bit_cnt_q + 1'b1;
                        fin_busy_q <= 1'b0;
                        state_q    <= last_bit ? S_FINAL : S_LOOP;
                    end
                end
                S_FINAL: begin
                    if (!fin_busy_q) begin
                        mont0_start_q <= 1'b1;
                        fin_busy_q    <= 1'b1;
                    end else if (i_mont0_done) begin
                        resp_valid_q <= 1'b1;
                        state_q      <= S_DONE;
                    end
                end
                S_DONE: begin
                    // Hold until the output skid takes the result
                    if (i_resp_ready) begin
                        resp_valid_q <= 1'b0;
                        state_q      <= S_IDLE;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (req_fire) begin
            req_q <= i_req;
            m_q   <= '0;
        end
        if ((state_q == S_PREP) && i_prep_done) begin
            t_q <= i_prep_t;
        end
        if (step_done) begin
            t_q <= i_mont1_p;
            // First set bit takes t as is, later ones use the product
            if (exp_bit) begin
                m_q <= m_set_q ? i_mont0_p : t_q;
            end
        end
        // d of zero never set m, result is plain one
        if (final_done) begin
            resp_q.m <= m_set_q ? i_mont0_p : one;
        end
    end

endmodule

// File: rsa_macros.svh
`ifndef RSA_MACROS_SVH
`define RSA_MACROS_SVH

// Operand width of the whole core
`define RSA_W 256

// Prep scans a 257-bit multiplier equal to 2^256
`define RSA_PREP_ITER (`RSA_W + 1)

// One Montgomery iteration per bit of operand a
`define RSA_MONT_ITER `RSA_W

`endif

// File: rsa_mont.sv
`include "rsa_macros.svh"

module rsa_mont (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_start,
    input  rsa_pkg::mont_op_t i_op,
    input  logic [`RSA_W-1:0] i_n,
    output logic              o_done,
    output logic [`RSA_W-1:0] o_p
);
    import rsa_pkg::*;

    mont_op_t                          op_q;
    logic                              busy_q;
    logic                              done_q;
    logic [$clog2(`RSA_MONT_ITER)-1:0] cnt_q;
    // Partial sum stays below 2n
    logic [`RSA_W:0]                   s_q;
    logic [`RSA_W+1:0]                 sum_b;
    logic [`RSA_W+1:0]                 sum_n;
    logic [`RSA_W:0]                   s_sub;
    logic                              a_bit;

    assign a_bit = op_q.a[cnt_q];

    // Add b on a set bit of a
    assign sum_b = {1'b0, s_q} + (a_bit ? {2'b00, op_q.b} : '0);

    // Make the sum even so the halving is exact mod n
    assign sum_n = sum_b + (sum_b[0] ? {2'b00, i_n} : '0);

    // Final conditional subtraction, visible in the done cycle
    assign s_sub = s_q - {1'b0, i_n};
    assign o_p   = (s_q >= {1'b0, i_n}) ? s_sub[`RSA_W-1:0] : s_q[`RSA_W-1:0];

    assign o_done = done_q;

    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (i_start) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == `RSA_MONT_ITER - 1) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // Operands captured once, sum held after done until the next start
    always_ff @(posedge i_clk) begin
        if (i_start) begin
            op_q <= i_op;
            s_q  <= '0;
        end else if (busy_q) begin
            s_q <= sum_n[`RSA_W+1:1];
        end
    end

    // Controller must wait for done before issuing the next product
    a_no_restart: assert property (@(posedge i_clk) disable iff (!i_rst)
        busy_q |-> !i_start);

endmodule

// File: rsa_pkg.sv
`include "rsa_macros.svh"

package rsa_pkg;

    // Request as it enters the core
    typedef struct packed {
        logic [`RSA_W-1:0] n;
        logic [`RSA_W-1:0] y;
        logic [`RSA_W-1:0] d;
    } rsa_req_t;

    // Result of y^d mod n
    typedef struct packed {
        logic [`RSA_W-1:0] m;
    } rsa_resp_t;

    // Operand pair for one Montgomery product a*b*2^-256 mod n
    typedef struct packed {
        logic [`RSA_W-1:0] a;
        logic [`RSA_W-1:0] b;
    } mont_op_t;

endpackage

// File: rsa_prep.sv
`include "rsa_macros.svh"

module rsa_prep (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_start,
    input  logic [`RSA_W-1:0] i_n,
    input  logic [`RSA_W-1:0] i_b,
    output logic              o_done,
    output logic [`RSA_W-1:0] o_t
);

    logic                                  busy_q;
    logic                                  done_q;
    logic [$clog2(`RSA_PREP_ITER)-1:0]     cnt_q;
    logic [`RSA_W-1:0]                     acc_q;
    logic [`RSA_W-1:0]                     t_q;
    logic [`RSA_PREP_ITER-1:0]             mult;
    logic [`RSA_W:0]                       acc_sum;
    logic [`RSA_W:0]                       acc_red;
    logic [`RSA_W:0]                       t_dbl;
    logic [`RSA_W:0]                       t_red;

    // Multiplier is 2^256 so only the top bit ever adds
    assign mult = {1'b1, {`RSA_W{1'b0}}};

    // Accumulate with one conditional subtraction
    assign acc_sum = {1'b0, acc_q} + {1'b0, t_q};
    assign acc_red = (acc_sum >= {1'b0, i_n}) ? acc_sum - {1'b0, i_n} : acc_sum;

    // t holds 2^k * b mod n at step k
    assign t_dbl = {t_q, 1'b0};
    assign t_red = (t_dbl >= {1'b0, i_n}) ? t_dbl - {1'b0, i_n} : t_dbl;

    assign o_done = done_q;
    assign o_t    = acc_q;

    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (i_start) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
                // Last step also raises done, acc is final in that cycle
                if (cnt_q == `RSA_PREP_ITER - 1) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_start) begin
            acc_q <= '0;
            t_q   <= i_b;
        end else if (busy_q) begin
            if (mult[cnt_q]) begin
                acc_q <= acc_red[`RSA_W-1:0];
            end
            t_q <= t_red[`RSA_W-1:0];
        end
    end

    // Base must already be reduced or the doubling overflows the single subtract
    a_base_reduced: assert property (@(posedge i_clk) disable iff (!i_rst)
        i_start |-> i_b < i_n);

endmodule

// File: rsa_skid.sv
module rsa_skid #(
    parameter type T = logic
) (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_valid,
    output logic o_ready,
    input  T     i_data,
    output logic o_valid,
    input  logic i_ready,
    output T     o_data
);

    logic valid_q;
    logic skid_valid_q;
    T     data_q;
    T     skid_q;
    logic in_fire;
    logic out_free;

    // Ready depends only on the skid slot so it comes straight from a flop
    assign o_ready  = ~skid_valid_q;
    assign o_valid  = valid_q;
    assign o_data   = data_q;
    assign in_fire  = i_valid & o_ready;
    assign out_free = i_ready | ~valid_q;

    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            valid_q      <= 1'b0;
            skid_valid_q <= 1'b0;
        end else if (out_free) begin
            // Output slot empties this cycle, refill from skid first
            if (skid_valid_q) begin
                valid_q      <= 1'b1;
                skid_valid_q <= 1'b0;
            end else begin
                valid_q <= in_fire;
            end
        end else if (in_fire) begin
            skid_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (out_free) begin
            if (skid_valid_q) begin
                data_q <= skid_q;
            end else if (in_fire) begin
                data_q <= i_data;
            end
        end
        if (in_fire && !out_free) begin
            skid_q <= i_data;
        end
    end

    // Stalled output holds its payload until the consumer takes it
    a_hold_stable: assert property (@(posedge i_clk) disable iff (!i_rst)
        o_valid && !i_ready |=> o_valid && $stable(o_data));

endmodule

// File: tb_rsa_core.sv
`include "rsa_macros.svh"

module tb_rsa_core;
    import rsa_pkg::*;

    // One full exponentiation takes roughly 66k cycles
    localparam int NUM_OPS    = 13;
    localparam int MAX_CYCLES = NUM_OPS * 70000;
    localparam int NUM_RND    = 12;

    logic              i_clk;
    logic              i_rst;
    logic              i_req_valid;
    logic              o_req_ready;
    rsa_req_t          i_req;
    logic              o_resp_valid;
    logic              i_resp_ready;
    rsa_resp_t         o_resp;

    integer            seed;
    integer            bp_bits;
    logic              bp_en;
    logic              stall_en;
    int                cycle_cnt;
    int                err_cnt;
    int                err_mark;
    int                req_cnt;
    int                resp_cnt;
    int                pass_tests;
    int                fail_tests;
    logic              held_valid;
    rsa_resp_t         held_resp;
    logic [`RSA_W-1:0] exp_m;
    logic [`RSA_W-1:0] exp_q[$];
    rsa_req_t          rnd_req[NUM_RND];
    rsa_req_t          req;

    rsa_core UUT (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_req_valid  (i_req_valid),
        .o_req_ready  (o_req_ready),
        .i_req        (i_req),
        .o_resp_valid (o_resp_valid),
        .i_resp_ready (i_resp_ready),
        .o_resp       (o_resp)
    );

    always #10 i_clk = ~i_clk;

    // Square-and-multiply from the least significant exponent bit
    function automatic logic [`RSA_W-1:0] ref_modexp(input logic [`RSA_W-1:0] n,
                                                     input logic [`RSA_W-1:0] y,
                                                     input logic [`RSA_W-1:0] d);
        logic [2*`RSA_W-1:0] r;
        logic [2*`RSA_W-1:0] b;
        logic [2*`RSA_W-1:0] nn;
        nn = {{`RSA_W{1'b0}}, n};
        r  = 1;
        b  = {{`RSA_W{1'b0}}, y} % nn;
        for (int i = 0; i < `RSA_W; i++) begin
            if (d[i]) begin
                r = (r * b) % nn;
            end
            b = (b * b) % nn;
        end
        return r[`RSA_W-1:0];
    endfunction

    function automatic logic [`RSA_W-1:0] rand_word();
        logic [`RSA_W-1:0] w;
        w = '0;
        for (int i = 0; i < `RSA_W / 32; i++) begin
            w[i*32 +: 32] = $random(seed);
        end
        return w;
    endfunction

    // Odd modulus with the top bit set, base already reduced
    function automatic rsa_req_t make_req();
        rsa_req_t r;
        r.n = rand_word() | {1'b1, {(`RSA_W-2){1'b0}}, 1'b1};
        r.y = rand_word() % r.n;
        r.d = rand_word();
        return r;
    endfunction

    task automatic send_req(input rsa_req_t r);
        @(negedge i_clk);
        i_req_valid = 1'b1;
        i_req       = r;
        // Ready is stable here and decides the transfer at the next rising edge
        while (!o_req_ready) begin
            @(negedge i_clk);
        end
        exp_q.push_back(ref_modexp(r.n, r.y, r.d));
        req_cnt++;
        @(negedge i_clk);
        i_req_valid = 1'b0;
    endtask

    task automatic wait_resp();
        while (resp_cnt < req_cnt) begin
            @(negedge i_clk);
        end
    endtask

    task automatic report_test(input string name);
        if (err_cnt == err_mark) begin
            pass_tests++;
            $display("Test %s: ok", name);
        end else begin
            fail_tests++;
            $display("Test %s: %0d errors", name, err_cnt - err_mark);
        end
        err_mark = err_cnt;
    endtask

    // Response side held off, or stalled at random while enabled
    always @(negedge i_clk) begin
        if (stall_en) begin
            i_resp_ready = 1'b0;
        end else if (bp_en) begin
            bp_bits      = $random(seed);
            i_resp_ready = bp_bits[0];
        end else begin
            i_resp_ready = 1'b1;
        end
    end

    always @(posedge i_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Compare every response handshake with the oldest expected result
    always @(posedge i_clk) begin
        if (!i_rst) begin
            held_valid = 1'b0;
        end else begin
            if (held_valid) begin
                assert (o_resp_valid) else begin
                    $display("Error at %0t: o_resp_valid = 0, expected 1 while stalled", $time);
                    err_cnt++;
                end
                assert (o_resp == held_resp) else begin
                    $display("Error at %0t: o_resp.m = %h, expected %h while stalled",
                             $time, o_resp.m, held_resp.m);
                    err_cnt++;
                end
            end
            if (o_resp_valid && i_resp_ready) begin
                resp_cnt++;
                assert (exp_q.size() > 0) else begin
                    $display("Error at %0t: a response came out with no request pending", $time);
                    err_cnt++;
                end
                if (exp_q.size() > 0) begin
                    exp_m = exp_q.pop_front();
                    assert (o_resp.m == exp_m) else begin
                        $display("Error at %0t: o_resp.m = %h, expected %h",
                                 $time, o_resp.m, exp_m);
                        err_cnt++;
                    end
                end
            end
            held_valid = o_resp_valid && !i_resp_ready;
            held_resp  = o_resp;
        end
    end

    initial begin
        seed         = 32'haf05df5b;
        i_clk        = 1'b0;
        i_rst        = 1'b0;
        i_req_valid  = 1'b0;
        i_req        = '0;
        i_resp_ready = 1'b1;
        bp_en        = 1'b0;
        stall_en     = 1'b0;
        cycle_cnt    = 0;
        err_cnt      = 0;
        err_mark     = 0;
        req_cnt      = 0;
        resp_cnt     = 0;
        pass_tests   = 0;
        fail_tests   = 0;
        held_valid   = 1'b0;
        for (int i = 0; i < NUM_RND; i++) begin
            rnd_req[i] = make_req();
        end
        repeat (4) @(negedge i_clk);
        i_rst = 1'b1;

        // Textbook example with a 12-bit modulus
        req   = '0;
        req.n = 3233;
        req.y = 65;
        req.d = 17;
        assert (ref_modexp(req.n, req.y, req.d) == 2790) else begin
            $display("Error at %0t: ref_modexp = %0d, expected 2790", $time,
                     ref_modexp(req.n, req.y, req.d));
            err_cnt++;
        end
        send_req(req);
        wait_resp();
        report_test("known small case");

        req   = rnd_req[0];
        req.d = '0;
        assert (ref_modexp(req.n, req.y, req.d) == 1) else begin
            $display("Error at %0t: ref_modexp = %h, expected 1", $time,
                     ref_modexp(req.n, req.y, req.d));
            err_cnt++;
        end
        send_req(req);
        wait_resp();
        report_test("exponent zero");

        req.d = 1;
        assert (ref_modexp(req.n, req.y, req.d) == req.y) else begin
            $display("Error at %0t: ref_modexp = %h, expected %h", $time,
                     ref_modexp(req.n, req.y, req.d), req.y);
            err_cnt++;
        end
        send_req(req);
        wait_resp();
        report_test("exponent one");

        req.d = '1;
        send_req(req);
        wait_resp();
        report_test("exponent all ones");

        for (int i = 1; i <= 4; i++) begin
            send_req(rnd_req[i]);
            wait_resp();
            report_test($sformatf("random %0d", i));
        end

        // Second request waits in the input skid while the first runs
        bp_en = 1'b1;
        send_req(rnd_req[5]);
        send_req(rnd_req[6]);
        wait_resp();
        bp_en = 1'b0;
        report_test("back-pressure");

        // Result held in the output skid while the next request runs and two more queue
        stall_en = 1'b1;
        send_req(rnd_req[7]);
        while (!o_resp_valid) begin
            @(negedge i_clk);
        end
        send_req(rnd_req[8]);
        send_req(rnd_req[9]);
        send_req(rnd_req[10]);
        repeat (1000) @(negedge i_clk);
        assert (o_resp_valid == 1'b1) else begin
            $display("Error at %0t: o_resp_valid = %b, expected 1 before reset", $time,
                     o_resp_valid);
            err_cnt++;
        end
        assert (o_req_ready == 1'b0) else begin
            $display("Error at %0t: o_req_ready = %b, expected 0 before reset", $time,
                     o_req_ready);
            err_cnt++;
        end
        i_rst    = 1'b0;
        stall_en = 1'b0;
        #1;
        assert (o_resp_valid == 1'b0) else begin
            $display("Error at %0t: o_resp_valid = %b, expected 0", $time, o_resp_valid);
            err_cnt++;
        end
        assert (o_req_ready == 1'b1) else begin
            $display("Error at %0t: o_req_ready = %b, expected 1", $time, o_req_ready);
            err_cnt++;
        end
        // Held and aborted requests never answer
        exp_q.delete();
        req_cnt = resp_cnt;
        repeat (4) @(negedge i_clk);
        i_rst = 1'b1;
        send_req(rnd_req[11]);
        wait_resp();
        report_test("reset mid-operation");

        $display("Tests passed %0d, failed %0d, errors %0d", pass_tests, fail_tests, err_cnt);
        if (fail_tests == 0 && err_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
